/* hw/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // operations the integer alu knows
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    // srl or sra, told apart by bit 30
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;

    // immediate formats, all sign extended except u
    function automatic logic [31:0] imm_i(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [31:0] imm_s(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    // bit 0 always zero for branch and jump offsets
    function automatic logic [31:0] imm_b(input logic [31:0] inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] imm_u(input logic [31:0] inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic logic [31:0] imm_j(input logic [31:0] inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

`default_nettype wire

/* hw/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

    // source of the value written back
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_LINK = 2'd2
    } wb_sel_e;

    // control word made in decode, carried down to memory
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        // second operand is the immediate
        logic    alu_src_imm;
        // first operand is the pc
        logic    a_is_pc;
        wb_sel_e wb_sel;
    } ctrl_t;

    // fetch to decode
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        rv_isa_pkg::alu_op_e   alu_op;
        logic [2:0]            funct3;
        logic [31:0]           pc;
        logic [31:0]           rs1_val;
        logic [31:0]           rs2_val;
        logic [31:0]           imm;
        logic [4:0]            rd;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  rd;
        logic [31:0] target;
        logic [31:0] link;
        logic        taken;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic        valid;
        logic        reg_write;
        wb_sel_e     wb_sel;
        logic [4:0]  rd;
        logic [31:0] alu_result;
        logic [31:0] load_data;
        logic [31:0] link;
    } mem_wb_t;

    // retiring register write, also the golden model port
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* hw/stage_reg.sv */
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      CLK,
    input  wire      RESET_N,
    // CLEAR or branch flush, turns the stage into a bubble
    input  wire      clear,
    input  payload_t d,
    output payload_t q
);

    // all zero payload also means valid low
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`default_nettype none

module reg_file (
    input  wire                CLK,
    input  wire                RESET_N,
    input  wire  [4:0]         rs1,
    input  wire  [4:0]         rs2,
    output logic [31:0]        rs1_data,
    output logic [31:0]        rs2_data,
    // writeback report doubles as write port
    input  rv_pipe_pkg::wb_t   wr
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.rd != 5'd0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rs1_data = (rs1 == 5'd0) ? 32'd0 :
                      (wr.valid && wr.rd == rs1) ? wr.data :
                      regs[rs1];

    assign rs2_data = (rs2 == 5'd0) ? 32'd0 :
                      (wr.valid && wr.rd == rs2) ? wr.data :
                      regs[rs2];

endmodule

`default_nettype wire

/* hw/decode_unit.sv */
`default_nettype none

module decode_unit (
    input  wire  [31:0]         inst,
    output rv_pipe_pkg::ctrl_t  ctrl,
    output rv_isa_pkg::alu_op_e alu_op,
    output logic [31:0]         imm
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;
    logic       is_reg;
    alu_op_e    arith_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign bit30  = inst[30];
    assign is_reg = (opcode == OP);

    // arithmetic op shared by OP and OP_IMM
    always_comb begin
        case (funct3)
            // addi has no sub form, bit 30 is immediate there
            F3_ADD:  arith_op = (is_reg && bit30) ? ALU_SUB : ALU_ADD;
            F3_SLL:  arith_op = ALU_SLL;
            F3_SLT:  arith_op = ALU_SLT;
            F3_SLTU: arith_op = ALU_SLTU;
            F3_XOR:  arith_op = ALU_XOR;
            // srai keeps bit 30 in its encoding too
            F3_SR:   arith_op = bit30 ? ALU_SRA : ALU_SRL;
            F3_OR:   arith_op = ALU_OR;
            F3_AND:  arith_op = ALU_AND;
            default: arith_op = ALU_ADD;
        endcase
    end

    always_comb begin
        // unknown opcode retires as a silent bubble
        ctrl   = '0;
        alu_op = ALU_ADD;
        imm    = '0;
        case (opcode)
            OP: begin
                ctrl.reg_write = 1'b1;
                alu_op         = arith_op;
            end
            OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                alu_op           = arith_op;
                imm              = imm_i(inst);
            end
            LOAD: begin
                // address is rs1 + imm
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_sel      = WB_LOAD;
                imm              = imm_i(inst);
            end
            STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_s(inst);
            end
            BRANCH: begin
                // rs1 - rs2 feeds the zero flag
                ctrl.branch = 1'b1;
                alu_op      = ALU_SUB;
                imm         = imm_b(inst);
            end
            JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = WB_LINK;
                imm            = imm_j(inst);
            end
            LUI: begin
                // first operand read from x0
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_u(inst);
            end
            AUIPC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.a_is_pc     = 1'b1;
                imm              = imm_u(inst);
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/int_alu.sv */
`default_nettype none

module int_alu (
    input  wire  [31:0]         a,
    input  wire  [31:0]         b,
    input  rv_isa_pkg::alu_op_e op,
    output logic [31:0]         result,
    output logic                zero
);

    import rv_isa_pkg::*;

    // only the low five bits shift
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_SLL: result = a << shamt;
            // set-less-than gives 1 or 0
            ALU_SLT: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {31'd0, a < b};
            end
            ALU_XOR: result = a ^ b;
            ALU_SRL: result = a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            ALU_OR:  result = a | b;
            ALU_AND: result = a & b;
            default: result = a + b;
        endcase
    end

    // used by beq and bne after a subtract
    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
`default_nettype none

module branch_unit (
    input  rv_pipe_pkg::id_ex_t ex,
    // alu zero flag from rs1 - rs2
    input  wire                 zero,
    output logic [31:0]         target,
    output logic [31:0]         link,
    output logic                taken
);

    import rv_isa_pkg::*;

    logic cond;

    // pc-relative target for both branches and jal
    assign target = ex.pc + ex.imm;
    assign link   = ex.pc + 32'd4;

    // condition only for beq and bne
    always_comb begin
        case (ex.funct3)
            F3_BEQ:  cond = zero;
            F3_BNE:  cond = !zero;
            default: cond = 1'b0;
        endcase
    end

    // bubbles never redirect
    assign taken = ex.valid && (ex.ctrl.jump || (ex.ctrl.branch && cond));

endmodule

`default_nettype wire

/* hw/rv_pipeline.sv */
`default_nettype none

module rv_pipeline #(
    parameter int ADDR_SIZE = 10
) (
    input  wire                  CLK,
    input  wire                  RESET_N,
    input  wire                  CLEAR,
    input  wire  [31:0]          idata,
    output logic [ADDR_SIZE-1:0] iaddr,
    output logic [ADDR_SIZE-1:0] daddr,
    input  wire  [31:0]          ddata_r,
    output logic [31:0]          ddata_w,
    output logic                 mem_read,
    output logic                 mem_write,
    output rv_pipe_pkg::wb_t     wb
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [31:0] pc;
    logic        flush;
    logic        clear_front;
    if_id_t      if_id_d, if_id_q;
    id_ex_t      id_ex_d, id_ex_q;
    ex_mem_t     ex_mem_d, ex_mem_q;
    mem_wb_t     mem_wb_d, mem_wb_q;
    ctrl_t       dec_ctrl;
    alu_op_e     dec_alu_op;
    logic [31:0] dec_imm;
    logic [4:0]  rs1_idx;
    logic [31:0] rs1_data, rs2_data;
    logic [31:0] op_a, op_b;
    logic [31:0] alu_result;
    logic        alu_zero;
    logic [31:0] br_target, br_link;
    logic        br_taken;

    // fetch
    // redirect comes from the memory stage
    assign flush = ex_mem_q.valid && ex_mem_q.taken;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (CLEAR) begin
            pc <= '0;
        end else if (flush) begin
            pc <= ex_mem_q.target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // word address into the rom
    assign iaddr = pc[ADDR_SIZE+1:2];

    assign if_id_d = '{valid: 1'b1, pc: pc, inst: idata};

    // the three younger stages die on a taken branch
    assign clear_front = CLEAR || flush;

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .CLK(CLK), .RESET_N(RESET_N), .clear(clear_front), .d(if_id_d), .q(if_id_q)
    );

    // decode
    decode_unit u_decode (
        .inst(if_id_q.inst), .ctrl(dec_ctrl), .alu_op(dec_alu_op), .imm(dec_imm)
    );

    // lui reads x0, its rs1 field is immediate bits
    assign rs1_idx = (if_id_q.inst[6:0] == LUI) ? 5'd0 : if_id_q.inst[19:15];

    reg_file u_regs (
        .CLK(CLK), .RESET_N(RESET_N),
        .rs1(rs1_idx), .rs2(if_id_q.inst[24:20]),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr(wb)
    );

    always_comb begin
        id_ex_d.valid   = if_id_q.valid;
        id_ex_d.ctrl    = dec_ctrl;
        id_ex_d.alu_op  = dec_alu_op;
        id_ex_d.funct3  = if_id_q.inst[14:12];
        id_ex_d.pc      = if_id_q.pc;
        id_ex_d.rs1_val = rs1_data;
        id_ex_d.rs2_val = rs2_data;
        id_ex_d.imm     = dec_imm;
        id_ex_d.rd      = if_id_q.inst[11:7];
    end

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .CLK(CLK), .RESET_N(RESET_N), .clear(clear_front), .d(id_ex_d), .q(id_ex_q)
    );

    // execute
    // operand muxes
    assign op_a = id_ex_q.ctrl.a_is_pc ? id_ex_q.pc : id_ex_q.rs1_val;
    assign op_b = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : id_ex_q.rs2_val;

    int_alu u_alu (
        .a(op_a), .b(op_b), .op(id_ex_q.alu_op), .result(alu_result), .zero(alu_zero)
    );

    branch_unit u_branch (
        .ex(id_ex_q), .zero(alu_zero),
        .target(br_target), .link(br_link), .taken(br_taken)
    );

    always_comb begin
        ex_mem_d.valid      = id_ex_q.valid;
        ex_mem_d.ctrl       = id_ex_q.ctrl;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = id_ex_q.rs2_val;
        ex_mem_d.rd         = id_ex_q.rd;
        ex_mem_d.target     = br_target;
        ex_mem_d.link       = br_link;
        ex_mem_d.taken      = br_taken;
    end

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .CLK(CLK), .RESET_N(RESET_N), .clear(clear_front), .d(ex_mem_d), .q(ex_mem_q)
    );

    // memory
    // strobes only from a live instruction
    assign daddr     = ex_mem_q.alu_result[ADDR_SIZE+1:2];
    assign ddata_w   = ex_mem_q.store_data;
    assign mem_read  = ex_mem_q.valid && ex_mem_q.ctrl.mem_read;
    assign mem_write = ex_mem_q.valid && ex_mem_q.ctrl.mem_write;

    always_comb begin
        mem_wb_d.valid      = ex_mem_q.valid;
        mem_wb_d.reg_write  = ex_mem_q.ctrl.reg_write;
        mem_wb_d.wb_sel     = ex_mem_q.ctrl.wb_sel;
        mem_wb_d.rd         = ex_mem_q.rd;
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.load_data  = ddata_r;
        mem_wb_d.link       = ex_mem_q.link;
    end

    // the branch itself still retires, so only CLEAR here
    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .CLK(CLK), .RESET_N(RESET_N), .clear(CLEAR), .d(mem_wb_d), .q(mem_wb_q)
    );

    // writeback
    always_comb begin
        wb.valid = mem_wb_q.valid && mem_wb_q.reg_write && (mem_wb_q.rd != 5'd0);
        wb.rd    = mem_wb_q.rd;
        case (mem_wb_q.wb_sel)
            WB_LOAD: wb.data = mem_wb_q.load_data;
            WB_LINK: wb.data = mem_wb_q.link;
            default: wb.data = mem_wb_q.alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`default_nettype none

module clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic CLK,
    output logic RESET_N
);

    timeunit 1ns;
    timeprecision 100ps;

    // free running clock
    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // reset low from time zero, released on a rising edge
    initial begin
        RESET_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        RESET_N <= 1'b1;
    end

endmodule

`default_nettype wire

/* bench/rv_pipeline_tb.sv */
`default_nettype none

module rv_pipeline_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_pipe_pkg::*;

    localparam int AW = 10;
    // jal x0, 0 spins in place
    localparam logic [31:0] HALT = 32'h0000_006f;
    // addi x0, x0, 0
    localparam logic [31:0] NOP  = 32'h0000_0013;

    logic          CLK;
    logic          RESET_N;
    logic          CLEAR;
    logic [31:0]   idata;
    logic [AW-1:0] iaddr;
    logic [AW-1:0] daddr;
    logic [31:0]   ddata_r;
    logic [31:0]   ddata_w;
    logic          mem_read;
    logic          mem_write;
    wb_t           wb;

    logic [31:0] rom  [0:(1<<AW)-1];
    logic [31:0] dram [0:(1<<AW)-1];
    // expected writes as {rd, data}, stores as {word addr, data}, loads as word addr
    logic [36:0]   full_wb [$];
    logic [41:0]   full_st [$];
    logic [AW-1:0] full_ld [$];
    logic [36:0]   exp_wb  [$];
    logic [41:0]   exp_st  [$];
    logic [AW-1:0] exp_ld  [$];
    logic [36:0]   exp_w;
    logic [41:0]   exp_s;
    logic [AW-1:0] exp_l;

    integer seed = 32'h98d8_7f23;
    string  test_name = "reset_idle";
    int     plen;
    int     errors;
    int     checks;
    int     tests;
    int     since_clear;
    longint limit_ns = 2000;

    clock_gen #(.PERIOD(40), .RESET_CYCLES(2)) u_clk (.CLK(CLK), .RESET_N(RESET_N));

    rv_pipeline #(.ADDR_SIZE(AW)) dut (
        .CLK(CLK), .RESET_N(RESET_N), .CLEAR(CLEAR),
        .idata(idata), .iaddr(iaddr),
        .daddr(daddr), .ddata_r(ddata_r), .ddata_w(ddata_w),
        .mem_read(mem_read), .mem_write(mem_write), .wb(wb)
    );

    // both memories answer in the same cycle
    assign idata   = rom[iaddr];
    assign ddata_r = dram[daddr];

    always @(posedge CLK) begin
        if (mem_write) begin
            dram[daddr] <= ddata_w;
        end
    end

    initial begin
        for (int i = 0; i < (1 << AW); i++) begin
            rom[i]  = HALT;
            dram[i] = 32'h9e37_79b9 * (i + 1);
        end
    end

    // cycles since the last edge that saw reset or CLEAR
    always @(posedge CLK) begin
        if (!RESET_N || CLEAR) begin
            since_clear <= 0;
        end else if (since_clear < 16) begin
            since_clear <= since_clear + 1;
        end
    end

    // instruction encoders
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3,
                                          logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(logic [6:0] op, logic [2:0] f3,
                                          logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // one of the source registers x1..x4
    function automatic logic [4:0] pick();
        logic [31:0] v;
        v = rnd();
        return 5'd1 + {3'd0, v[1:0]};
    endfunction

    // alu as the isa defines it; sub and sra pick the alternate forms
    function automatic logic [31:0] calc_alu(logic [2:0] f3, logic sub, logic sra,
                                             logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return sra ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // program builder
    task automatic open_prog();
        for (int i = 0; i < (1 << AW); i++) begin
            rom[i] = HALT;
        end
        plen = 0;
    endtask

    task automatic put(logic [31:0] inst);
        rom[plen] = inst;
        plen++;
    endtask

    // two nops keep the next consumer clear of the hazard
    task automatic emit(logic [31:0] inst);
        put(inst);
        put(NOP);
        put(NOP);
    endtask

    task automatic load_reg(logic [4:0] rd, logic [31:0] v);
        logic [31:0] up;
        up = v + 32'h800;
        emit(enc_u(7'h37, rd, up[31:12]));
        emit(enc_i(7'h13, 3'd0, rd, rd, v[11:0]));
    endtask

    // taken branch lands past the victim addi
    task automatic skip_over(logic [31:0] br, logic [4:0] victim_rd);
        emit(br);
        emit(enc_i(7'h13, 3'd0, victim_rd, 5'd0, 12'h155));
    endtask

    task automatic build_alu();
        logic [2:0]  ops_i [6];
        logic [31:0] v;
        open_prog();
        ops_i = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        for (int k = 1; k <= 4; k++) begin
            load_reg(k[4:0], rnd());
        end
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(7'h00, f[2:0], 5'd5 + f[4:0], pick(), pick()));
        end
        emit(enc_r(7'h20, 3'd0, 5'd13, pick(), pick()));
        emit(enc_r(7'h20, 3'd5, 5'd14, pick(), pick()));
        for (int j = 0; j < 6; j++) begin
            v = rnd();
            emit(enc_i(7'h13, ops_i[j], 5'd15 + j[4:0], pick(), v[11:0]));
        end
        // shift immediates with srai marked by bit 30
        v = rnd();
        emit(enc_i(7'h13, 3'd1, 5'd21, pick(), {7'h00, v[4:0]}));
        v = rnd();
        emit(enc_i(7'h13, 3'd5, 5'd22, pick(), {7'h00, v[4:0]}));
        v = rnd();
        emit(enc_i(7'h13, 3'd5, 5'd23, pick(), {7'h20, v[4:0]}));
        v = rnd();
        emit(enc_u(7'h17, 5'd24, v[31:12]));
        v = rnd();
        emit(enc_u(7'h37, 5'd25, v[31:12]));
        put(HALT);
    endtask

    task automatic build_mem();
        logic [31:0] base;
        open_prog();
        base = rnd() & 32'h1fc;
        emit(enc_i(7'h13, 3'd0, 5'd1, 5'd0, base[11:0]));
        load_reg(5'd2, rnd());
        load_reg(5'd3, rnd());
        emit(enc_s(5'd1, 5'd2, 12'd8));
        emit(enc_s(5'd1, 5'd3, 12'd40));
        emit(enc_i(7'h03, 3'd2, 5'd5, 5'd1, 12'd8));
        emit(enc_i(7'h03, 3'd2, 5'd6, 5'd1, 12'd40));
        // untouched word gives back the fill pattern
        emit(enc_i(7'h03, 3'd2, 5'd7, 5'd1, 12'd100));
        put(HALT);
    endtask

    task automatic build_branch();
        logic [31:0] v;
        open_prog();
        v = rnd();
        load_reg(5'd1, v);
        load_reg(5'd2, v);
        load_reg(5'd3, v ^ 32'd1);
        skip_over(enc_b(3'd0, 5'd1, 5'd2, 13'd24), 5'd10);
        skip_over(enc_b(3'd0, 5'd1, 5'd3, 13'd24), 5'd11);
        skip_over(enc_b(3'd1, 5'd1, 5'd3, 13'd24), 5'd12);
        skip_over(enc_b(3'd1, 5'd1, 5'd2, 13'd24), 5'd13);
        // squashed store behind the jump
        emit(enc_j(5'd4, 21'd24));
        emit(enc_s(5'd0, 5'd1, 12'd64));
        emit(enc_i(7'h13, 3'd0, 5'd20, 5'd4, 12'd0));
        put(HALT);
    endtask

    // sequential isa model over the rom
    task automatic run_model();
        logic [31:0] r [0:31];
        logic [31:0] m [0:(1<<AW)-1];
        logic [31:0] pc, inst, a, b, res, ea, nxt;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wr;
        int          steps;
        full_wb.delete();
        full_st.delete();
        full_ld.delete();
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        m = dram;
        pc = '0;
        steps = 0;
        while (rom[pc[AW+1:2]] != HALT && steps < 4000) begin
            inst = rom[pc[AW+1:2]];
            rd   = inst[11:7];
            f3   = inst[14:12];
            a    = r[inst[19:15]];
            b    = r[inst[24:20]];
            wr   = 1'b0;
            res  = '0;
            nxt  = pc + 32'd4;
            case (inst[6:0])
                7'h37: begin
                    wr  = 1'b1;
                    res = {inst[31:12], 12'h000};
                end
                7'h17: begin
                    wr  = 1'b1;
                    res = pc + {inst[31:12], 12'h000};
                end
                7'h13: begin
                    wr  = 1'b1;
                    res = calc_alu(f3, 1'b0, inst[30], a, {{20{inst[31]}}, inst[31:20]});
                end
                7'h33: begin
                    wr  = 1'b1;
                    res = calc_alu(f3, inst[30], inst[30], a, b);
                end
                7'h03: begin
                    wr  = 1'b1;
                    ea  = a + {{20{inst[31]}}, inst[31:20]};
                    res = m[ea[AW+1:2]];
                    full_ld.push_back(ea[AW+1:2]);
                end
                7'h23: begin
                    ea = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    m[ea[AW+1:2]] = b;
                    full_st.push_back({ea[AW+1:2], b});
                end
                7'h63: begin
                    if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                        nxt = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                    inst[11:8], 1'b0};
                    end
                end
                7'h6f: begin
                    wr  = 1'b1;
                    res = pc + 32'd4;
                    nxt = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                inst[30:21], 1'b0};
                end
                default: ;
            endcase
            if (wr && rd != 5'd0) begin
                r[rd] = res;
                full_wb.push_back({rd, res});
            end
            pc = nxt;
            steps++;
        end
    endtask

    // CLEAR seen at one edge, program loaded while held
    task automatic hold_clear();
        @(posedge CLK);
        CLEAR <= 1'b1;
        @(posedge CLK);
    endtask

    task automatic run_test(input string name, input bit mid_clear);
        int half;
        int err_start;
        test_name = name;
        run_model();
        exp_wb    = full_wb;
        exp_st    = full_st;
        exp_ld    = full_ld;
        half      = full_wb.size() / 2;
        err_start = errors;
        limit_ns  = $time + 2 * (mid_clear ? 2 : 1) * plen * 40 + 2000;
        CLEAR <= 1'b0;
        if (mid_clear) begin
            while (exp_wb.size() > half) @(posedge CLK);
            CLEAR <= 1'b1;
            @(posedge CLK);
            CLEAR <= 1'b0;
            // whole sequence again from address 0
            exp_wb = full_wb;
            exp_st = full_st;
            exp_ld = full_ld;
        end
        while (exp_wb.size() != 0 || exp_st.size() != 0 || exp_ld.size() != 0) begin
            @(posedge CLK);
        end
        // room for any stray write to show up
        repeat (6) @(posedge CLK);
        tests++;
        $display("test %s done, %0d errors", name, errors - err_start);
    endtask

    // checkers, sampled away from the rising edge
    always @(negedge CLK) begin
        if (since_clear == 0) begin
            assert (iaddr == '0) else begin
                $display("mismatch in test %s: expected iaddr 0, actual iaddr %0d",
                         test_name, iaddr);
                errors++;
            end
        end
        if (since_clear < 3) begin
            assert (!mem_read && !mem_write) else begin
                $display("memory strobe before any instruction reached memory in test %s",
                         test_name);
                errors++;
            end
        end
        if (since_clear < 4) begin
            assert (!wb.valid) else begin
                $display("register write before any instruction retired in test %s",
                         test_name);
                errors++;
            end
        end
        if (wb.valid) begin
            checks++;
            assert (exp_wb.size() != 0) else begin
                $display("unexpected write to x%0d in test %s", wb.rd, test_name);
                errors++;
            end
            if (exp_wb.size() != 0) begin
                exp_w = exp_wb.pop_front();
                assert ({wb.rd, wb.data} == exp_w) else begin
                    $display("mismatch in test %s: expected x%0d=%h, actual x%0d=%h",
                             test_name, exp_w[36:32], exp_w[31:0], wb.rd, wb.data);
                    errors++;
                end
            end
        end
        if (mem_write) begin
            checks++;
            assert (exp_st.size() != 0) else begin
                $display("unexpected store to word %0d in test %s", daddr, test_name);
                errors++;
            end
            if (exp_st.size() != 0) begin
                exp_s = exp_st.pop_front();
                assert ({daddr, ddata_w} == exp_s) else begin
                    $display("mismatch in test %s: expected [%0d]=%h, actual [%0d]=%h",
                             test_name, exp_s[41:32], exp_s[31:0], daddr, ddata_w);
                    errors++;
                end
            end
        end
        if (mem_read) begin
            checks++;
            assert (exp_ld.size() != 0) else begin
                $display("unexpected load from word %0d in test %s", daddr, test_name);
                errors++;
            end
            if (exp_ld.size() != 0) begin
                exp_l = exp_ld.pop_front();
                assert (daddr == exp_l) else begin
                    $display("mismatch in test %s: expected load [%0d], actual load [%0d]",
                             test_name, exp_l, daddr);
                    errors++;
                end
            end
        end
    end

    // watchdog, limit moves with each test's length
    initial begin
        while ($time < limit_ns) @(posedge CLK);
        $display("timeout in test %s, the run did not finish in time", test_name);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        CLEAR  = 1'b0;
        errors = 0;
        checks = 0;
        tests  = 0;
        wait (RESET_N === 1'b1);
        // rom holds only the halt loop here
        repeat (6) @(posedge CLK);
        tests++;
        $display("test reset_idle done, %0d errors", errors);
        hold_clear();
        build_alu();
        run_test("alu", 1'b0);
        hold_clear();
        build_mem();
        run_test("load_store", 1'b0);
        hold_clear();
        build_branch();
        run_test("branch_jump", 1'b0);
        hold_clear();
        build_alu();
        run_test("clear_restart", 1'b1);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/stage_reg.sv
hw/reg_file.sv
hw/decode_unit.sv
hw/int_alu.sv
hw/branch_unit.sv
hw/rv_pipeline.sv
bench/clock_gen.sv
bench/rv_pipeline_tb.sv
